/* logic/snake_pkg.sv */
// field geometry and tile codes shared by the food-placement blocks
// coordinates are 6 bits wide, so the field may not exceed 64 tiles per axis
`default_nettype none

package snake_pkg;

    // field size in tiles
    localparam int MAP_WIDTH  = 62;
    localparam int MAP_HEIGHT = 46;

    localparam int COORD_W = 6;

    // points stay one tile away from the border on each side
    localparam int RANGE_X = MAP_WIDTH - 2;
    localparam int RANGE_Y = MAP_HEIGHT - 2;

    // seed counter values after reset
    localparam int SEED_X_START = 1;
    localparam int SEED_Y_START = 23;

    // both snakes start vertical, head at the top
    localparam int START_LENGTH = 3;

    localparam int START_POS_X = 10;
    localparam int START_POS_Y = 20;

    localparam int START_POS_X_2 = 50;
    localparam int START_POS_Y_2 = 20;

    // one code per map position
    typedef enum logic [1:0] {
        EMPTY  = 2'd0,
        SNAKE1 = 2'd1,
        SNAKE2 = 2'd2,
        POINT  = 2'd3
    } tile_t;

    typedef enum logic {
        MENU = 1'b0,
        GAME = 1'b1
    } game_mode_t;

endpackage

`default_nettype wire

/* logic/game_control.sv */
// mode tracking for point placement; mode is sampled on every clk_75 edge
// start and seed_rdy are one-cycle strobes, pick carries collisions seen in game only
`timescale 1ns/10ps
`default_nettype none

module game_control (
    input  wire logic                   clk_75,
    input  wire logic                   rst,
    input  wire snake_pkg::game_mode_t  mode,
    input  wire logic                   collision,
    output logic                        menu,
    output logic                        start,
    output logic                        seed_rdy,
    output logic                        pick
);

    snake_pkg::game_mode_t mode_prev;
    logic                  launch;
    logic                  entering_game;

    // seed counters run on this level
    assign menu = (mode == snake_pkg::MENU);

    assign entering_game = (mode == snake_pkg::GAME) && (mode_prev == snake_pkg::MENU);

    always_ff @(posedge clk_75) begin
        if (rst) begin
            mode_prev <= snake_pkg::MENU;
        end else begin
            mode_prev <= mode;
        end
    end

    // one strobe serves both the pickers and the serial link
    always_ff @(posedge clk_75) begin
        if (rst) begin
            launch <= 1'b0;
        end else begin
            launch <= entering_game;
        end
    end

    assign start    = launch;
    assign seed_rdy = launch;

    // collisions while in the menu are dropped here
    always_ff @(posedge clk_75) begin
        if (rst) begin
            pick <= 1'b0;
        end else begin
            pick <= collision && (mode == snake_pkg::GAME);
        end
    end

endmodule

`default_nettype wire

/* logic/axis_picker.sv */
// seed counter and point coordinate for one field axis
// RANGE must not exceed 63; a point of 0 means no point has been placed yet
`timescale 1ns/10ps
`default_nettype none

module axis_picker #(
    parameter int RANGE      = snake_pkg::RANGE_X,
    parameter int SEED_START = snake_pkg::SEED_X_START
) (
    input  wire logic                           clk_75,
    input  wire logic                           rst,
    input  wire logic                           menu,
    input  wire logic                           start,
    input  wire logic                           pick,
    input  wire logic [snake_pkg::COORD_W-1:0]  seed_in,
    output logic      [snake_pkg::COORD_W-1:0]  seed,
    output logic      [snake_pkg::COORD_W-1:0]  point,
    output logic                                point_upd
);

    localparam int CW = snake_pkg::COORD_W;

    // one extra bit so the seed sum cannot overflow before the modulo
    localparam logic [CW:0] RANGE_W = (CW + 1)'(RANGE);

    logic [CW:0]   seed_sum;
    logic [CW-1:0] start_point;
    logic [CW-1:0] lfsr_next;
    logic [CW-1:0] pick_point;

    // shift up, feedback from bit 5 into bits 0 and 1
    function automatic logic [CW-1:0] lfsr_step(input logic [CW-1:0] v);
        return {v[4:1], v[0] ^ v[5], v[5]};
    endfunction

    assign seed_sum    = {1'b0, seed} + {1'b0, seed_in};
    assign start_point = CW'(seed_sum % RANGE_W) + CW'(1);

    assign lfsr_next  = lfsr_step(point);
    assign pick_point = CW'({1'b0, lfsr_next} % RANGE_W) + CW'(1);

    // free-running while the menu is shown, frozen in game
    always_ff @(posedge clk_75) begin
        if (rst) begin
            seed <= CW'(SEED_START);
        end else if (menu) begin
            if (seed == CW'(RANGE - 1)) begin
                seed <= '0;
            end else begin
                seed <= seed + CW'(1);
            end
        end
    end

    // start wins if a pick lands in the same cycle
    always_ff @(posedge clk_75) begin
        if (rst) begin
            point <= '0;
        end else if (start) begin
            point <= start_point;
        end else if (pick) begin
            point <= pick_point;
        end
    end

    always_ff @(posedge clk_75) begin
        if (rst) begin
            point_upd <= 1'b0;
        end else begin
            point_upd <= start || pick;
        end
    end

endmodule

`default_nettype wire

/* logic/tile_map.sv */
// tile storage for the whole field, reset loads both starting snakes
// writes outside the field are dropped and reads outside it return EMPTY
`timescale 1ns/10ps
`default_nettype none

module tile_map (
    input  wire logic                           clk_75,
    input  wire logic                           rst,
    input  wire logic                           wr_en,
    input  wire logic [snake_pkg::COORD_W-1:0]  wr_x,
    input  wire logic [snake_pkg::COORD_W-1:0]  wr_y,
    input  wire snake_pkg::tile_t               wr_tile,
    input  wire logic                           point_upd,
    input  wire logic [snake_pkg::COORD_W-1:0]  point_x,
    input  wire logic [snake_pkg::COORD_W-1:0]  point_y,
    input  wire logic [snake_pkg::COORD_W-1:0]  rd_x,
    input  wire logic [snake_pkg::COORD_W-1:0]  rd_y,
    output snake_pkg::tile_t                    rd_tile
);

    localparam int CW = snake_pkg::COORD_W;
    localparam int W  = snake_pkg::MAP_WIDTH;
    localparam int H  = snake_pkg::MAP_HEIGHT;

    // row-major, tiles[y][x]
    snake_pkg::tile_t tiles [H][W];

    logic wr_ok;
    logic pt_ok;
    logic rd_ok;

    function automatic logic in_field(input logic [CW-1:0] x, input logic [CW-1:0] y);
        return (int'(x) < W) && (int'(y) < H);
    endfunction

    // snakes lie in one column, rows from the head downwards
    function automatic snake_pkg::tile_t start_tile(input int row, input int col);
        snake_pkg::tile_t t;
        t = snake_pkg::EMPTY;
        if (col == snake_pkg::START_POS_X &&
            row >= snake_pkg::START_POS_Y &&
            row <  snake_pkg::START_POS_Y + snake_pkg::START_LENGTH) begin
            t = snake_pkg::SNAKE1;
        end else if (col == snake_pkg::START_POS_X_2 &&
                     row >= snake_pkg::START_POS_Y_2 &&
                     row <  snake_pkg::START_POS_Y_2 + snake_pkg::START_LENGTH) begin
            t = snake_pkg::SNAKE2;
        end
        return t;
    endfunction

    assign wr_ok = wr_en && in_field(wr_x, wr_y);
    assign pt_ok = point_upd && in_field(point_x, point_y);
    assign rd_ok = in_field(rd_x, rd_y);

    always_ff @(posedge clk_75) begin
        if (rst) begin
            for (int r = 0; r < H; r++) begin
                for (int c = 0; c < W; c++) begin
                    tiles[r][c] <= start_tile(r, c);
                end
            end
        end else begin
            if (wr_ok) begin
                tiles[wr_y][wr_x] <= wr_tile;
            end
            // later assignment, so the point overrides a snake write on the same tile
            if (pt_ok) begin
                tiles[point_y][point_x] <= snake_pkg::POINT;
            end
        end
    end

    // display port, no register in the path
    always_comb begin
        if (rd_ok) begin
            rd_tile = tiles[rd_y][rd_x];
        end else begin
            rd_tile = snake_pkg::EMPTY;
        end
    end

endmodule

`default_nettype wire

/* logic/point_unit.sv */
// food placement top: mode control, one picker per axis and the tile map
// seed_x_in and seed_y_in must be stable in the cycle after the switch to game
`timescale 1ns/10ps
`default_nettype none

module point_unit (
    input  wire logic                           clk_75,
    input  wire logic                           rst,
    input  wire snake_pkg::game_mode_t          mode,
    input  wire logic [snake_pkg::COORD_W-1:0]  seed_x_in,
    input  wire logic [snake_pkg::COORD_W-1:0]  seed_y_in,
    input  wire logic                           collision,
    input  wire logic                           wr_en,
    input  wire logic [snake_pkg::COORD_W-1:0]  wr_x,
    input  wire logic [snake_pkg::COORD_W-1:0]  wr_y,
    input  wire snake_pkg::tile_t               wr_tile,
    input  wire logic [snake_pkg::COORD_W-1:0]  rd_x,
    input  wire logic [snake_pkg::COORD_W-1:0]  rd_y,
    output snake_pkg::tile_t                    rd_tile,
    output logic      [snake_pkg::COORD_W-1:0]  seed_x,
    output logic      [snake_pkg::COORD_W-1:0]  seed_y,
    output logic                                seed_rdy,
    output logic      [snake_pkg::COORD_W-1:0]  point_x,
    output logic      [snake_pkg::COORD_W-1:0]  point_y
);

    logic menu;
    logic start;
    logic pick;
    logic point_upd;

    game_control u_ctrl (
        .clk_75    (clk_75),
        .rst       (rst),
        .mode      (mode),
        .collision (collision),
        .menu      (menu),
        .start     (start),
        .seed_rdy  (seed_rdy),
        .pick      (pick)
    );

    axis_picker #(
        .RANGE      (snake_pkg::RANGE_X),
        .SEED_START (snake_pkg::SEED_X_START)
    ) u_pick_x (
        .clk_75    (clk_75),
        .rst       (rst),
        .menu      (menu),
        .start     (start),
        .pick      (pick),
        .seed_in   (seed_x_in),
        .seed      (seed_x),
        .point     (point_x),
        .point_upd (point_upd)
    );

    // y loads in lockstep with x, so its own update strobe is not needed
    axis_picker #(
        .RANGE      (snake_pkg::RANGE_Y),
        .SEED_START (snake_pkg::SEED_Y_START)
    ) u_pick_y (
        .clk_75    (clk_75),
        .rst       (rst),
        .menu      (menu),
        .start     (start),
        .pick      (pick),
        .seed_in   (seed_y_in),
        .seed      (seed_y),
        .point     (point_y),
        .point_upd ()
    );

    tile_map u_map (
        .clk_75    (clk_75),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_x      (wr_x),
        .wr_y      (wr_y),
        .wr_tile   (wr_tile),
        .point_upd (point_upd),
        .point_x   (point_x),
        .point_y   (point_y),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .rd_tile   (rd_tile)
    );

endmodule

`default_nettype wire

/* sim/point_unit_tests.svh */
// directed tests for point_unit, included inside the testbench module
// tests share the point model and must run in the order the testbench calls them
`ifndef POINT_UNIT_TESTS_SVH
`define POINT_UNIT_TESTS_SVH

// one clock edge, then 1 ns to the drive point
task automatic step();
    @(posedge clk_75);
    if (!rst && mode == snake_pkg::MENU) begin
        menu_edges++;
    end
    #1;
endtask

task automatic expect_eq(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
        errors++;
        $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic read_tile(input logic [CW-1:0] x, input logic [CW-1:0] y,
                         output snake_pkg::tile_t t);
    rd_x = x;
    rd_y = y;
    #1;
    t = rd_tile;
endtask

task automatic expect_tile(input logic [CW-1:0] x, input logic [CW-1:0] y,
                           input snake_pkg::tile_t exp);
    snake_pkg::tile_t t;
    read_tile(x, y, t);
    expect_eq($sformatf("tile (%0d,%0d)", x, y), int'(t), int'(exp));
endtask

// call right after step, the write lands at the next edge
task automatic write_tile(input logic [CW-1:0] x, input logic [CW-1:0] y,
                          input snake_pkg::tile_t t);
    wr_en   = 1'b1;
    wr_x    = x;
    wr_y    = y;
    wr_tile = t;
    step();
    wr_en = 1'b0;
endtask

task automatic finish_test(input string name);
    $display("%s: done, %0d errors", name, errors - err_mark);
    err_mark = errors;
endtask

task automatic reset_layout();
    expect_eq("seed_x", int'(seed_x), snake_pkg::SEED_X_START);
    expect_eq("seed_y", int'(seed_y), snake_pkg::SEED_Y_START);
    expect_eq("point_x", int'(point_x), 0);
    expect_eq("point_y", int'(point_y), 0);
    // one row per cycle
    for (int r = 0; r < snake_pkg::MAP_HEIGHT; r++) begin
        step();
        for (int c = 0; c < snake_pkg::MAP_WIDTH; c++) begin
            expect_tile(CW'(c), CW'(r), start_layout(c, r));
        end
    end
    finish_test("reset layout");
endtask

task automatic seed_count_and_rdy();
    int n;
    int sx;
    int sy;
    n = int'($urandom % (MAX_MENU - 20)) + 20;
    for (int i = 0; i < n; i++) begin
        step();
        expect_eq("seed_rdy in menu", int'(seed_rdy), 0);
    end
    sx = seed_after(snake_pkg::SEED_X_START, snake_pkg::RANGE_X, menu_edges);
    sy = seed_after(snake_pkg::SEED_Y_START, snake_pkg::RANGE_Y, menu_edges);
    expect_eq("seed_x in menu", int'(seed_x), sx);
    expect_eq("seed_y in menu", int'(seed_y), sy);
    seed_x_in = CW'($urandom % 64);
    seed_y_in = CW'($urandom % 64);
    mode = snake_pkg::GAME;
    // strobe only in the cycle after the switch edge
    for (int i = 0; i < 3; i++) begin
        step();
        expect_eq("seed_rdy", int'(seed_rdy), (i == 0) ? 1 : 0);
        expect_eq("seed_x in game", int'(seed_x), sx);
        expect_eq("seed_y in game", int'(seed_y), sy);
    end
    exp_px = wrap_coord(sx + int'(seed_x_in), snake_pkg::RANGE_X);
    exp_py = wrap_coord(sy + int'(seed_y_in), snake_pkg::RANGE_Y);
    finish_test("seed counting and seed_rdy");
endtask

task automatic first_point();
    expect_eq("first point_x", int'(point_x), int'(exp_px));
    expect_eq("first point_y", int'(point_y), int'(exp_py));
    expect_tile(exp_px, exp_py, snake_pkg::POINT);
    placed.push_back({exp_px, exp_py});
    finish_test("first point");
endtask

// len collisions on consecutive edges
task automatic collision_burst(input int len);
    logic [CW-1:0] xs [8];
    logic [CW-1:0] ys [8];
    xs[0] = next_pick(exp_px, snake_pkg::RANGE_X);
    ys[0] = next_pick(exp_py, snake_pkg::RANGE_Y);
    for (int j = 1; j < len; j++) begin
        xs[j] = next_pick(xs[j-1], snake_pkg::RANGE_X);
        ys[j] = next_pick(ys[j-1], snake_pkg::RANGE_Y);
    end
    step();
    collision = 1'b1;
    for (int i = 0; i <= len + 1; i++) begin
        step();
        collision = (i + 1 < len);
        if (i >= 1 && i <= len) begin
            expect_eq("point_x after collision", int'(point_x), int'(xs[i-1]));
            expect_eq("point_y after collision", int'(point_y), int'(ys[i-1]));
        end
        if (i >= 2) begin
            expect_tile(xs[i-2], ys[i-2], snake_pkg::POINT);
        end
    end
    for (int j = 0; j < len; j++) begin
        placed.push_back({xs[j], ys[j]});
    end
    exp_px = xs[len-1];
    exp_py = ys[len-1];
endtask

task automatic collision_placement();
    collision_burst(1);
    collision_burst(2);
    collision_burst(1);
    collision_burst(3);
    finish_test("collision placement");
endtask

task automatic menu_collision();
    logic [CW-1:0]    qx;
    logic [CW-1:0]    qy;
    int               base;
    int               fx;
    int               fy;
    qx = next_pick(exp_px, snake_pkg::RANGE_X);
    qy = next_pick(exp_py, snake_pkg::RANGE_Y);
    base = menu_edges;
    fx = seed_after(snake_pkg::SEED_X_START, snake_pkg::RANGE_X, menu_edges);
    fy = seed_after(snake_pkg::SEED_Y_START, snake_pkg::RANGE_Y, menu_edges);
    step();
    mode      = snake_pkg::MENU;
    collision = 1'b1;
    step();
    collision = 1'b0;
    repeat (3) step();
    expect_eq("point_x after menu collision", int'(point_x), int'(exp_px));
    expect_eq("point_y after menu collision", int'(point_y), int'(exp_py));
    expect_tile(qx, qy, model_tile(int'(qx), int'(qy)));
    expect_eq("seed_x resumed", int'(seed_x),
              seed_after(fx, snake_pkg::RANGE_X, menu_edges - base));
    expect_eq("seed_y resumed", int'(seed_y),
              seed_after(fy, snake_pkg::RANGE_Y, menu_edges - base));
    finish_test("collision in menu");
endtask

task automatic external_write();
    int sx;
    int sy;
    step();
    write_tile(CW'(30), CW'(40), snake_pkg::SNAKE1);
    expect_tile(CW'(30), CW'(40), snake_pkg::SNAKE1);
    step();
    write_tile(CW'(50), CW'(21), snake_pkg::EMPTY);
    expect_tile(CW'(50), CW'(21), snake_pkg::EMPTY);
    // new game, then a snake write on the placement edge of the first point
    step();
    sx = seed_after(snake_pkg::SEED_X_START, snake_pkg::RANGE_X, menu_edges);
    sy = seed_after(snake_pkg::SEED_Y_START, snake_pkg::RANGE_Y, menu_edges);
    seed_x_in = CW'($urandom % 64);
    seed_y_in = CW'($urandom % 64);
    mode = snake_pkg::GAME;
    exp_px = wrap_coord(sx + int'(seed_x_in), snake_pkg::RANGE_X);
    exp_py = wrap_coord(sy + int'(seed_y_in), snake_pkg::RANGE_Y);
    step();
    step();
    write_tile(exp_px, exp_py, snake_pkg::SNAKE2);
    expect_eq("point_x on conflict", int'(point_x), int'(exp_px));
    expect_eq("point_y on conflict", int'(point_y), int'(exp_py));
    expect_tile(exp_px, exp_py, snake_pkg::POINT);
    finish_test("external write");
endtask

`endif

/* sim/point_unit_tb.sv */
// testbench for point_unit, directed tests come from point_unit_tests.svh
// inputs change 1 ns after the rising edge, outputs are read after that
`timescale 1ns/10ps
`default_nettype none

module point_unit_tb;

    localparam int CW       = snake_pkg::COORD_W;
    localparam int MAX_MENU = 120;
    // reset, one cycle per map row, longest menu wait, then the game-mode tests
    localparam int RUN_CYCLES      = 16 + snake_pkg::MAP_HEIGHT + MAX_MENU + 60;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 200;

    logic                  clk_75;
    logic                  rst;
    snake_pkg::game_mode_t mode;
    logic [CW-1:0]         seed_x_in;
    logic [CW-1:0]         seed_y_in;
    logic                  collision;
    logic                  wr_en;
    logic [CW-1:0]         wr_x;
    logic [CW-1:0]         wr_y;
    snake_pkg::tile_t      wr_tile;
    logic [CW-1:0]         rd_x;
    logic [CW-1:0]         rd_y;
    snake_pkg::tile_t      rd_tile;
    logic [CW-1:0]         seed_x;
    logic [CW-1:0]         seed_y;
    logic                  seed_rdy;
    logic [CW-1:0]         point_x;
    logic [CW-1:0]         point_y;

    int            checks;
    int            errors;
    int            err_mark;
    // edges seen with mode in MENU since reset, drives the seed model
    int            menu_edges;
    logic [CW-1:0] exp_px;
    logic [CW-1:0] exp_py;
    // every point placed so far, {x, y}
    logic [2*CW-1:0] placed [$];

    point_unit dut (.*);

    always #50 clk_75 = ~clk_75;

    function automatic int seed_after(input int start, input int range, input int n);
        return (start + n) % range;
    endfunction

    // points land in 1..range, away from the border
    function automatic logic [CW-1:0] wrap_coord(input int v, input int range);
        return CW'(v % range + 1);
    endfunction

    function automatic logic [CW-1:0] next_pick(input logic [CW-1:0] v, input int range);
        logic [CW-1:0] n;
        n = {v[4:0], 1'b0};
        n[0] = v[5];
        n[1] = v[0] ^ v[5];
        return wrap_coord(int'(n), range);
    endfunction

    function automatic snake_pkg::tile_t start_layout(input int x, input int y);
        if (x == snake_pkg::START_POS_X && y >= snake_pkg::START_POS_Y &&
            y - snake_pkg::START_POS_Y < snake_pkg::START_LENGTH) begin
            return snake_pkg::SNAKE1;
        end
        if (x == snake_pkg::START_POS_X_2 && y >= snake_pkg::START_POS_Y_2 &&
            y - snake_pkg::START_POS_Y_2 < snake_pkg::START_LENGTH) begin
            return snake_pkg::SNAKE2;
        end
        return snake_pkg::EMPTY;
    endfunction

    // start layout with every placed point on top, before any external write
    function automatic snake_pkg::tile_t model_tile(input int x, input int y);
        snake_pkg::tile_t t;
        t = start_layout(x, y);
        foreach (placed[i]) begin
            if (placed[i] == {CW'(x), CW'(y)}) begin
                t = snake_pkg::POINT;
            end
        end
        return t;
    endfunction

    `include "point_unit_tests.svh"

    initial begin
        clk_75    = 1'b0;
        rst       = 1'b1;
        mode      = snake_pkg::MENU;
        seed_x_in = '0;
        seed_y_in = '0;
        collision = 1'b0;
        wr_en     = 1'b0;
        wr_x      = '0;
        wr_y      = '0;
        wr_tile   = snake_pkg::EMPTY;
        rd_x      = '0;
        rd_y      = '0;
        checks     = 0;
        errors     = 0;
        err_mark   = 0;
        menu_edges = 0;
        exp_px     = '0;
        exp_py     = '0;
        void'($urandom(32'h875));
        repeat (16) @(posedge clk_75);
        #1;
        rst = 1'b0;
        reset_layout();
        seed_count_and_rdy();
        first_point();
        collision_placement();
        menu_collision();
        external_write();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_75);
        $display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+sim
logic/snake_pkg.sv
logic/game_control.sv
logic/axis_picker.sv
logic/tile_map.sv
logic/point_unit.sv
sim/point_unit_tb.sv

/* run.sh */
#!/bin/sh
# builds the point_unit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f sources.f \
    --top-module point_unit_tb \
    -o point_unit_sim

./obj_dir/point_unit_sim | tee sim.log

if grep -q "^Regression passed$" sim.log; then
    echo "simulation ok"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
